/* Bender.yml */
package:
  name: sensor_i2c

sources:
  - files:
      - rtl/sensi2c_cmd_pkg.sv
      - rtl/i2c_line_pkg.sv
      - rtl/cmd_port.sv
      - rtl/frame_pages.sv
      - rtl/cmd_ram.sv
      - rtl/i2c_sequencer.sv
      - rtl/sensor_i2c_top.sv
  - target: simulation
    files:
      - sim/tb_sensor_i2c.sv

/* compile.f */
rtl/sensi2c_cmd_pkg.sv
rtl/i2c_line_pkg.sv
rtl/cmd_port.sv
rtl/frame_pages.sv
rtl/cmd_ram.sv
rtl/i2c_sequencer.sv
rtl/sensor_i2c_top.sv
sim/tb_sensor_i2c.sv

/* rtl/cmd_port.sv */
// accepts one request per four-phase req/ack cycle; ack is withheld while the page sweep runs
`default_nettype none

module cmd_port (
    input  wire                             mclk,
    input  wire                             reset_cmd,
    input  wire                             req,
    input  wire sensi2c_cmd_pkg::cmd_req_t  cmd_req,
    input  wire                             sweeping,
    output logic                            ack,
    output logic                            wr_stb,
    output sensi2c_cmd_pkg::page_t          wr_offset,
    output sensi2c_cmd_pkg::cmd_word_t      wr_word,
    output i2c_line_pkg::i2c_cfg_t          cfg,
    output logic                            clear_all
);

    logic acc;      // request taken this cycle, ack rises next
    logic ctrl_stb; // control word waiting in wr_word

    assign acc = req && !ack && !sweeping;

    // handshake and strobes
    always_ff @(posedge mclk) begin
        if (reset_cmd) begin
            ack      <= 1'b0;
            wr_stb   <= 1'b0;
            ctrl_stb <= 1'b0;
        end else begin
            ack      <= req && (ack || !sweeping); // hold until req drops
            wr_stb   <= acc && !cmd_req.is_ctrl;
            ctrl_stb <= acc && cmd_req.is_ctrl;
        end
    end

    // payload, control words share the word register
    always_ff @(posedge mclk) begin
        if (acc) begin
            wr_offset <= cmd_req.frame_offset;
            wr_word   <= cmd_req.word;
        end
    end

    // configuration, one cycle after ack
    always_ff @(posedge mclk) begin
        if (reset_cmd) begin
            cfg.enrun  <= 1'b0;
            cfg.nbytes <= '0;
            cfg.qdly   <= i2c_line_pkg::QDLY_RESET;
            clear_all  <= 1'b0;
        end else begin
            clear_all <= ctrl_stb && wr_word[sensi2c_cmd_pkg::CTRL_RESET_BIT];
            if (ctrl_stb) begin
                if (wr_word[sensi2c_cmd_pkg::CTRL_RESET_BIT])
                    cfg.enrun <= 1'b0;                  // reset also stops
                else if (wr_word[sensi2c_cmd_pkg::CTRL_RUN_SET_BIT])
                    cfg.enrun <= wr_word[sensi2c_cmd_pkg::CTRL_RUN_VAL_BIT];
                if (wr_word[sensi2c_cmd_pkg::CTRL_BYTES_SET_BIT])
                    cfg.nbytes <= wr_word[sensi2c_cmd_pkg::CTRL_BYTES_SET_BIT - 1 -:
                                          $bits(i2c_line_pkg::byte_cnt_t)];
                if (wr_word[sensi2c_cmd_pkg::CTRL_DLY_SET_BIT])
                    cfg.qdly <= wr_word[sensi2c_cmd_pkg::CTRL_DLY_SET_BIT - 1 -:
                                        $bits(i2c_line_pkg::qdly_t)];
            end
        end
    end

    // ack never rises once the host has let go of req
    a_ack_needs_req: assert property (@(posedge mclk) disable iff (reset_cmd)
        $rose(ack) |-> req);

endmodule

`default_nettype wire

/* rtl/cmd_ram.sv */
// command memory of 16 pages by 64 words; byte 3 of a word is bits 31:24; read data lags rd_en by 2 clocks
`default_nettype none

module cmd_ram (
    input  wire                                   mclk,
    input  wire                                   ram_we,
    input  wire [sensi2c_cmd_pkg::RD_ADDR_W-3:0]  ram_waddr,
    input  wire sensi2c_cmd_pkg::cmd_word_t       ram_wdata,
    input  wire                                   rd_en,
    input  wire [sensi2c_cmd_pkg::RD_ADDR_W-1:0]  rd_addr,   // {page, pointer, byte}
    output logic [7:0]                            rd_data
);

    sensi2c_cmd_pkg::cmd_word_t mem [sensi2c_cmd_pkg::PAGES << $bits(sensi2c_cmd_pkg::wptr_t)];
    sensi2c_cmd_pkg::cmd_word_t rd_word; // ram read stage
    logic [1:0] rd_sel;                  // byte lane for the output stage

    always_ff @(posedge mclk) begin
        if (ram_we)
            mem[ram_waddr] <= ram_wdata;
    end

    always_ff @(posedge mclk) begin
        if (rd_en) begin
            rd_word <= mem[rd_addr[sensi2c_cmd_pkg::RD_ADDR_W-1:2]];
            rd_sel  <= rd_addr[1:0];
        end
        rd_data <= rd_word[rd_sel*8 +: 8]; // output register
    end

endmodule

`default_nettype wire

/* rtl/frame_pages.sv */
// up to 64 commands per page without overflow check; offset 15 shares the page cleared at the next frame sync
`default_nettype none

module frame_pages (
    input  wire                                        mclk,
    input  wire                                        reset_cmd,
    input  wire                                        clear_all,
    input  wire                                        frame_sync,
    input  wire                                        wr_stb,
    input  wire sensi2c_cmd_pkg::page_t                wr_offset,
    input  wire sensi2c_cmd_pkg::cmd_word_t            wr_word,
    input  wire                                        cmd_done,
    output logic                                       ram_we,
    output logic [sensi2c_cmd_pkg::RD_ADDR_W-3:0]      ram_waddr, // {page, pointer}
    output sensi2c_cmd_pkg::cmd_word_t                 ram_wdata,
    output logic                                       cmd_avail,
    output logic [sensi2c_cmd_pkg::RD_ADDR_W-3:0]      rd_base,   // {page, pointer}
    output logic                                       sweeping
);

    sensi2c_cmd_pkg::wptr_t wptr_mem [sensi2c_cmd_pkg::PAGES]; // per-page write pointers
    sensi2c_cmd_pkg::page_t open_page;  // asap writes go here
    sensi2c_cmd_pkg::page_t prev_page;  // expired page, cleared on next advance
    sensi2c_cmd_pkg::page_t rd_page;    // sequencer reads from here
    sensi2c_cmd_pkg::wptr_t rd_ptr;
    sensi2c_cmd_pkg::page_t wr_sel;     // target page of the incoming write
    sensi2c_cmd_pkg::page_t wr_page;
    sensi2c_cmd_pkg::wptr_t wr_ptr;
    logic [$clog2(i2c_line_pkg::RESET_SWEEP):0] sweep_cnt;
    logic sync_pend;  // frame sync waiting for a write to finish
    logic adv;        // open page steps this cycle
    logic rd_adv;     // read page steps this cycle
    logic restart;
    logic rd_empty;

    assign restart   = reset_cmd || clear_all;
    assign sweeping  = (sweep_cnt != '0);
    assign wr_sel    = open_page + wr_offset;                  // wraps modulo 16
    assign {wr_page, wr_ptr} = ram_waddr;
    assign adv       = sync_pend && !wr_stb && !ram_we && !sweeping;
    assign rd_empty  = (rd_ptr == wptr_mem[rd_page]);
    assign cmd_avail = !sweeping && !rd_empty;                 // pointers are junk mid-sweep
    assign rd_adv    = !sweeping && rd_empty && (rd_page != open_page);
    assign rd_base   = {rd_page, rd_ptr};

    // ram write one cycle after the strobe
    always_ff @(posedge mclk) begin
        if (reset_cmd)
            ram_we <= 1'b0;
        else
            ram_we <= wr_stb;
        if (wr_stb) begin
            ram_waddr <= {wr_sel, wptr_mem[wr_sel]};
            ram_wdata <= wr_word;
        end
    end

    // pointer memory: sweep, clear expired page, or bump after a write
    always_ff @(posedge mclk) begin
        if (sweeping)
            wptr_mem[sensi2c_cmd_pkg::page_t'(sweep_cnt - 1'b1)] <= '0;
        else if (adv)
            wptr_mem[prev_page] <= '0;
        else if (ram_we)
            wptr_mem[wr_page] <= wr_ptr + 1'b1;
    end

    always_ff @(posedge mclk) begin
        if (restart)
            sweep_cnt <= ($clog2(i2c_line_pkg::RESET_SWEEP) + 1)'(i2c_line_pkg::RESET_SWEEP);
        else if (sweeping)
            sweep_cnt <= sweep_cnt - 1'b1;

        if (reset_cmd)
            sync_pend <= 1'b0;
        else if (frame_sync)
            sync_pend <= 1'b1;                   // a new pulse wins over the advance
        else if (adv)
            sync_pend <= 1'b0;
    end

    // open and read page tracking
    always_ff @(posedge mclk) begin
        if (restart) begin
            open_page <= '0;
            prev_page <= '1;
            rd_page   <= '0;
            rd_ptr    <= '0;
        end else begin
            if (adv) begin
                open_page <= open_page + 1'b1;
                prev_page <= open_page;
            end
            if (rd_adv) begin
                rd_page <= rd_page + 1'b1;
                rd_ptr  <= '0;
            end else if (adv && (rd_page == prev_page))
                rd_ptr <= '0;                    // unsent leftovers are dropped
            else if (cmd_done && cmd_avail)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // read side never overtakes the write side of its page
    a_rd_behind_wr: assert property (@(posedge mclk) disable iff (reset_cmd)
        !sweeping |-> (rd_ptr <= wptr_mem[rd_page]));

endmodule

`default_nettype wire

/* rtl/i2c_line_pkg.sv */
// i2c line-side types; a quarter bit lasts qdly+3 clocks so the slowest bit is 4*258 clocks
`default_nettype none

package i2c_line_pkg;

    typedef logic [1:0] byte_cnt_t; // bytes after the slave address
    typedef logic [7:0] qdly_t;     // quarter-bit length minus 3

    typedef enum logic [2:0] {IDLE, FETCH, START, DATA, ACK, STOP} seq_state_t;

    // sequencer configuration from the control word
    typedef struct packed {
        logic      enrun;  // sequencer may start new commands
        byte_cnt_t nbytes;
        qdly_t     qdly;
    } i2c_cfg_t;

    // pin drive, en low releases the line
    typedef struct packed {
        logic scl;
        logic sda;
        logic scl_en;
        logic sda_en;
    } line_drv_t;

    localparam qdly_t QDLY_RESET  = 8'd100;
    localparam int    RESET_SWEEP = 16;     // pointer entries cleared per sweep

endpackage

`default_nettype wire

/* rtl/i2c_sequencer.sv */
// write-only i2c master without ack check or arbitration; clear_all aborts a write mid-byte
`default_nettype none

module i2c_sequencer (
    input  wire                           mclk,
    input  wire                           reset_cmd,
    input  wire                           clear_all,
    input  wire i2c_line_pkg::i2c_cfg_t   cfg,
    input  wire                           cmd_avail,
    input  wire [7:0]                     rd_data,
    output logic                          rd_en,
    output logic [1:0]                    rd_byte_sel, // 3 is the slave address byte
    output logic                          cmd_done,
    output logic                          running,
    output i2c_line_pkg::line_drv_t       line
);

    i2c_line_pkg::seq_state_t state;
    i2c_line_pkg::byte_cnt_t  bytes_left;
    logic [8:0] qcnt;     // quarter down-counter
    logic [1:0] qidx;     // quarter within the bit
    logic [2:0] bit_cnt;  // data bit within the byte
    logic [1:0] fcnt;     // ram latency count
    logic [8:0] sr;       // msb is on the line, ones shift in
    logic timed, q_end, bit_end, fetched, first, sda_bus;

    assign timed    = state inside {i2c_line_pkg::START, i2c_line_pkg::DATA,
                                    i2c_line_pkg::ACK, i2c_line_pkg::STOP};
    assign q_end    = (qcnt == '0);
    assign bit_end  = q_end && (qidx == 2'd3);
    assign first    = (rd_byte_sel == 2'd3);
    assign rd_en    = (state == i2c_line_pkg::FETCH) && (fcnt == 2'd0);
    assign fetched  = (state == i2c_line_pkg::FETCH) && (fcnt == 2'd2); // rd_data valid
    assign cmd_done = (state == i2c_line_pkg::STOP) && bit_end;
    assign running  = (state != i2c_line_pkg::IDLE);
    assign sda_bus  = !line.sda_en || line.sda;  // level seen on the wire

    // quarter timer, qdly+3 clocks per quarter
    always_ff @(posedge mclk) begin
        if (reset_cmd || !timed || q_end)
            qcnt <= {1'b0, cfg.qdly} + 9'd2;
        else
            qcnt <= qcnt - 1'b1;
        if (reset_cmd || !timed)
            qidx <= '0;
        else if (q_end)
            qidx <= qidx + 1'b1;
    end

    always_ff @(posedge mclk) begin
        if (reset_cmd || clear_all) begin
            state       <= i2c_line_pkg::IDLE;
            bytes_left  <= '0;
            rd_byte_sel <= 2'd3;
            bit_cnt     <= '0;
            fcnt        <= '0;
        end else begin
            case (state)
                i2c_line_pkg::IDLE: if (cfg.enrun && cmd_avail) begin
                    state       <= i2c_line_pkg::FETCH;
                    bytes_left  <= cfg.nbytes;   // latched per command
                    rd_byte_sel <= 2'd3;
                    fcnt        <= '0;
                end
                i2c_line_pkg::FETCH: begin
                    fcnt <= fcnt + 1'b1;
                    if (fetched) begin
                        state   <= first ? i2c_line_pkg::START : i2c_line_pkg::DATA;
                        bit_cnt <= '0;
                    end
                end
                i2c_line_pkg::START: if (bit_end) state <= i2c_line_pkg::DATA;
                i2c_line_pkg::DATA: if (bit_end) begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_cnt == 3'd7)
                        state <= i2c_line_pkg::ACK;
                end
                i2c_line_pkg::ACK: if (bit_end) begin
                    if (bytes_left != '0) begin
                        bytes_left  <= bytes_left - 1'b1;
                        rd_byte_sel <= rd_byte_sel - 1'b1; // next lower byte
                        fcnt        <= '0;
                        state       <= i2c_line_pkg::FETCH;
                    end else
                        state <= i2c_line_pkg::STOP;
                end
                i2c_line_pkg::STOP: if (bit_end) state <= i2c_line_pkg::IDLE;
                default: state <= i2c_line_pkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge mclk) begin
        if (fetched)
            sr <= {rd_data, 1'b1};
        else if ((state == i2c_line_pkg::DATA) && bit_end)
            sr <= {sr[7:0], 1'b1};
    end

    // pin drive, quarters 0..3 per bit
    always_ff @(posedge mclk) begin
        if (reset_cmd)
            line <= '{scl: 1'b1, sda: 1'b1, scl_en: 1'b0, sda_en: 1'b0};
        else begin
            case (state)
                i2c_line_pkg::START:   // sda falls in q2 with scl high
                    line <= '{scl: qidx != 2'd3, sda: !qidx[1], scl_en: 1'b1, sda_en: 1'b1};
                i2c_line_pkg::DATA:    // scl high in q1 and q2
                    line <= '{scl: ^qidx, sda: sr[8], scl_en: 1'b1, sda_en: 1'b1};
                i2c_line_pkg::ACK:     // sda left to the slave
                    line <= '{scl: ^qidx, sda: 1'b1, scl_en: 1'b1, sda_en: 1'b0};
                i2c_line_pkg::STOP:    // sda rises in q3 with scl high
                    line <= '{scl: qidx[1], sda: qidx == 2'd3, scl_en: 1'b1, sda_en: 1'b1};
                i2c_line_pkg::FETCH:   // hold scl low between bytes
                    line <= '{scl: first, sda: 1'b1, scl_en: !first, sda_en: 1'b0};
                default:
                    line <= '{scl: 1'b1, sda: 1'b1, scl_en: 1'b0, sda_en: 1'b0};
            endcase
        end
    end

    // data and ack bits never move sda while scl is high
    a_sda_stable: assert property (@(posedge mclk) disable iff (reset_cmd)
        $changed(sda_bus) && !$past(clear_all, 2) &&
        !($past(state) inside {i2c_line_pkg::START, i2c_line_pkg::STOP})
        |-> !line.scl && !$past(line.scl));

endmodule

`default_nettype wire

/* rtl/sensi2c_cmd_pkg.sv */
// host-side types and control-word layout; a page holds up to 64 commands and overflow is not detected
`default_nettype none

package sensi2c_cmd_pkg;

    localparam int PAGES     = 16;   // one page per frame, modulo 16
    localparam int RD_ADDR_W = 12;   // {page, pointer, byte}

    typedef logic [3:0]  page_t;     // frame page index
    typedef logic [5:0]  wptr_t;     // command slot within a page
    typedef logic [31:0] cmd_word_t; // i2c command or control word

    // one host request, fifo command or control word
    typedef struct packed {
        logic      is_ctrl;      // 1 selects the control word
        page_t     frame_offset; // frames ahead of the open page, 0 is asap
        cmd_word_t word;         // slave addr in 31:24, then payload msb first
    } cmd_req_t;

    // control word bits
    localparam int CTRL_RESET_BIT     = 14; // clear all pages and stop
    localparam int CTRL_RUN_SET_BIT   = 13; // load run state from bit 12
    localparam int CTRL_RUN_VAL_BIT   = 12;
    localparam int CTRL_BYTES_SET_BIT = 11; // load byte count from 10:9
    localparam int CTRL_DLY_SET_BIT   = 8;  // load quarter-bit delay from 7:0

endpackage

`default_nettype wire

/* rtl/sensor_i2c_top.sv */
// scl is push-pull while a write runs; sda needs an external pull-up for the ack slot and idle bus
`default_nettype none

module sensor_i2c_top (
    input  wire                             mclk,
    input  wire                             reset_cmd,
    input  wire                             frame_sync,
    input  wire                             req,
    input  wire sensi2c_cmd_pkg::cmd_req_t  cmd_req,
    output logic                            ack,
    output logic                            i2c_busy,
    output logic                            scl_out,
    output logic                            sda_out,
    output logic                            scl_en,
    output logic                            sda_en
);

    sensi2c_cmd_pkg::page_t     wr_offset;
    sensi2c_cmd_pkg::cmd_word_t wr_word;
    sensi2c_cmd_pkg::cmd_word_t ram_wdata;
    i2c_line_pkg::i2c_cfg_t     cfg;
    i2c_line_pkg::line_drv_t    line;
    logic [sensi2c_cmd_pkg::RD_ADDR_W-3:0] ram_waddr;
    logic [sensi2c_cmd_pkg::RD_ADDR_W-3:0] rd_base;
    logic [1:0] rd_byte_sel;
    logic [7:0] rd_data;
    logic wr_stb, clear_all, sweeping, ram_we, cmd_avail, rd_en, cmd_done, running;

    cmd_port cmd_port_i (
        .mclk, .reset_cmd, .req, .cmd_req, .sweeping,
        .ack, .wr_stb, .wr_offset, .wr_word, .cfg, .clear_all
    );

    frame_pages frame_pages_i (
        .mclk, .reset_cmd, .clear_all, .frame_sync, .wr_stb, .wr_offset, .wr_word, .cmd_done,
        .ram_we, .ram_waddr, .ram_wdata, .cmd_avail, .rd_base, .sweeping
    );

    cmd_ram cmd_ram_i (
        .mclk, .ram_we, .ram_waddr, .ram_wdata, .rd_en,
        .rd_addr ({rd_base, rd_byte_sel}),  // byte lane below page and pointer
        .rd_data
    );

    i2c_sequencer i2c_sequencer_i (
        .mclk, .reset_cmd, .clear_all, .cfg, .cmd_avail, .rd_data,
        .rd_en, .rd_byte_sel, .cmd_done, .running, .line
    );

    assign i2c_busy = cmd_avail || running;  // work queued on the read page or on the bus
    assign scl_out  = line.scl;
    assign sda_out  = line.sda;
    assign scl_en   = line.scl_en;
    assign sda_en   = line.sda_en;

endmodule

`default_nettype wire

/* sim/tb_sensor_i2c.sv */
// testbench for sensor_i2c_top; no slave model, so sda reads back high in every ack slot
`default_nettype none

module tb_sensor_i2c;
    timeunit 1ns;
    timeprecision 1ps;

    localparam i2c_line_pkg::qdly_t QDLY_TB = 8'd1;  // 4 clocks per quarter bit
    localparam int IMM_PER_N   = 4;    // immediate commands per byte count
    localparam int N_DEFER     = 6;
    localparam int N_HELD      = 3;
    localparam int N_SENT      = 4 * IMM_PER_N + N_DEFER + N_HELD + 1;
    localparam int HOLD_CYCLES = 300;  // well past fetch and start latency
    localparam int WATCHDOG_NS = N_SENT * 40 * 4 * (QDLY_TB + 3) * 4 + 20000;

    typedef struct packed {
        sensi2c_cmd_pkg::page_t     page;
        sensi2c_cmd_pkg::cmd_word_t word;
    } pend_t;

    logic mclk, reset_cmd, frame_sync, req;
    sensi2c_cmd_pkg::cmd_req_t cmd_req;
    logic ack, i2c_busy, scl_out, sda_out, scl_en, sda_en;
    logic scl_bus, sda_bus;                          // wire levels with pull-ups

    sensi2c_cmd_pkg::cmd_word_t exp_q[$];            // due commands in send order
    pend_t                      pend_q[$];           // deferred commands with target page
    sensi2c_cmd_pkg::page_t     open_model;
    i2c_line_pkg::byte_cnt_t    nbytes_model;
    sensi2c_cmd_pkg::page_t     off_tb;
    sensi2c_cmd_pkg::cmd_word_t word_tb;
    logic [31:0] lfsr;
    logic [31:0] rx_word;
    logic [7:0]  rx_byte;
    logic        scl_prev, sda_prev, in_frame, bus_quiet;
    int          bit_cnt, rx_bytes, writes_seen;

    sensor_i2c_top sensor_i2c_top_i (
        .mclk, .reset_cmd, .frame_sync, .req, .cmd_req,
        .ack, .i2c_busy, .scl_out, .sda_out, .scl_en, .sda_en
    );

    assign scl_bus = !scl_en || scl_out;
    assign sda_bus = !sda_en || sda_out;

    initial begin
        mclk = 1'b0;
        forever #2 mclk = ~mclk;
    end

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else
            stop_on_error($sformatf("CHECK FAILED at %0t ns: %s is %h, expected %h",
                                    $time, name, got, exp));
    endtask

    // fibonacci lfsr x^32+x^22+x^2+x+1, one step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            v    = {v[30:0], lfsr[31]};
            lfsr = {lfsr[30:0], fb};
        end
        return v;
    endfunction

    function automatic sensi2c_cmd_pkg::cmd_word_t ctrl_word(input logic rst, input logic run_set,
            input logic run_val, input logic bytes_set, input i2c_line_pkg::byte_cnt_t n,
            input logic dly_set, input i2c_line_pkg::qdly_t q);
        sensi2c_cmd_pkg::cmd_word_t w;
        w = '0;
        w[sensi2c_cmd_pkg::CTRL_RESET_BIT]     = rst;
        w[sensi2c_cmd_pkg::CTRL_RUN_SET_BIT]   = run_set;
        w[sensi2c_cmd_pkg::CTRL_RUN_VAL_BIT]   = run_val;
        w[sensi2c_cmd_pkg::CTRL_BYTES_SET_BIT] = bytes_set;
        w[sensi2c_cmd_pkg::CTRL_BYTES_SET_BIT-1 -: 2] = n;
        w[sensi2c_cmd_pkg::CTRL_DLY_SET_BIT]   = dly_set;
        w[sensi2c_cmd_pkg::CTRL_DLY_SET_BIT-1 -: 8]   = q;
        return w;
    endfunction

    // one four-phase transfer
    task automatic host_write(input logic ctrl, input sensi2c_cmd_pkg::page_t off,
                              input sensi2c_cmd_pkg::cmd_word_t w);
        @(posedge mclk);
        req     <= 1'b1;
        cmd_req <= '{is_ctrl: ctrl, frame_offset: off, word: w};
        @(posedge mclk);
        while (!ack) @(posedge mclk);   // sweep can hold ack back
        req <= 1'b0;
        while (ack) @(posedge mclk);
    endtask

    task automatic queue_command(input sensi2c_cmd_pkg::page_t off,
                                 input sensi2c_cmd_pkg::cmd_word_t w);
        host_write(1'b0, off, w);
        if (off == '0)
            exp_q.push_back(w);                               // due at once
        else
            pend_q.push_back('{page: open_model + off, word: w});
    endtask

    // pulse, then move the now open page's commands to the due list
    task automatic pulse_frame_sync();
        pend_t keep[$];
        @(posedge mclk);
        frame_sync <= 1'b1;
        @(posedge mclk);
        frame_sync <= 1'b0;
        open_model = open_model + 4'd1;
        keep = {};
        for (int i = 0; i < pend_q.size(); i++) begin
            if (pend_q[i].page == open_model)
                exp_q.push_back(pend_q[i].word);
            else
                keep.push_back(pend_q[i]);
        end
        pend_q = keep;
        repeat (6) @(posedge mclk);                           // page advance settles
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0 || i2c_busy) @(posedge mclk);
    endtask

    task automatic compare_write();
        sensi2c_cmd_pkg::cmd_word_t exp;
        if (exp_q.size() == 0)
            stop_on_error("an I2C write appeared on the bus while no command was due");
        else begin
            exp = exp_q.pop_front();
            check_value("byte count", 32'(rx_bytes), 32'(nbytes_model) + 32'd1);
            check_value("i2c write", rx_word, exp >> (8 * (3 - int'(nbytes_model))));
            writes_seen++;
        end
    endtask

    // bus decoder, sampled mid-cycle where the pins are stable
    always @(negedge mclk) begin
        if (reset_cmd) begin
            scl_prev = 1'b1;
            sda_prev = 1'b1;
            in_frame = 1'b0;
        end else begin
            if (scl_prev && scl_bus && sda_prev && !sda_bus) begin        // start
                assert (!bus_quiet) else
                    stop_on_error("a start condition appeared while the sequencer was held");
                in_frame = 1'b1;
                bit_cnt  = 0;
                rx_bytes = 0;
                rx_byte  = '0;
                rx_word  = '0;
            end else if (in_frame && scl_prev && scl_bus && !sda_prev && sda_bus) begin
                in_frame = 1'b0;                                            // stop
                compare_write();
            end else if (in_frame && !scl_prev && scl_bus) begin
                if (bit_cnt == 8) begin                                     // ack slot
                    assert (!sda_en) else
                        stop_on_error($sformatf(
                            "CHECK FAILED at %0t ns: sda_en is 1, expected 0 in ack slot", $time));
                    rx_word = {rx_word[23:0], rx_byte};
                    rx_bytes++;
                    bit_cnt = 0;
                end else begin
                    rx_byte = {rx_byte[6:0], sda_bus};
                    bit_cnt++;
                end
            end
            scl_prev = scl_bus;
            sda_prev = sda_bus;
        end
    end

    // four-phase order seen from the host
    ack_after_req: assert property (@(negedge mclk) disable iff (reset_cmd) $rose(ack) |-> req)
        else stop_on_error("ack rose while no request was pending");
    ack_drop_after_req: assert property (@(negedge mclk) disable iff (reset_cmd)
        $fell(ack) |-> !req)
        else stop_on_error("ack fell while the request was still high");

    initial begin
        #(WATCHDOG_NS);
        stop_on_error("timeout: the bus traffic did not finish in the expected time");
    end

    initial begin
        reset_cmd    = 1'b1;
        req          = 1'b0;
        frame_sync   = 1'b0;
        cmd_req      = '0;
        bus_quiet    = 1'b0;
        open_model   = '0;
        nbytes_model = '0;
        writes_seen  = 0;
        lfsr         = 32'hfda87483;
        repeat (4) @(posedge mclk);
        reset_cmd <= 1'b0;
        repeat (i2c_line_pkg::RESET_SWEEP + 4) @(posedge mclk);
        check_value("ack", 32'(ack), 32'd0);
        check_value("scl_en", 32'(scl_en), 32'd0);
        check_value("sda_en", 32'(sda_en), 32'd0);
        check_value("i2c_busy", 32'(i2c_busy), 32'd0);

        // immediate commands for each byte count
        host_write(1'b1, '0, ctrl_word(1'b0, 1'b1, 1'b1, 1'b0, 2'd0, 1'b1, QDLY_TB));
        for (int n = 0; n < 4; n++) begin
            nbytes_model = i2c_line_pkg::byte_cnt_t'(n);
            host_write(1'b1, '0, ctrl_word(1'b0, 1'b0, 1'b0, 1'b1, nbytes_model, 1'b0, '0));
            repeat (IMM_PER_N) queue_command('0, take_bits(32));
            wait_drain();
        end

        // deferred commands, 1..4 frames ahead
        repeat (N_DEFER) begin
            off_tb  = sensi2c_cmd_pkg::page_t'(take_bits(2)) + 4'd1;
            word_tb = take_bits(32);
            queue_command(off_tb, word_tb);
        end
        repeat (5) begin
            pulse_frame_sync();
            wait_drain();
        end

        // held while stopped, sent after run
        nbytes_model = 2'd2;
        host_write(1'b1, '0, ctrl_word(1'b0, 1'b1, 1'b0, 1'b1, nbytes_model, 1'b0, '0));
        bus_quiet = 1'b1;
        repeat (N_HELD) queue_command('0, take_bits(32));
        repeat (HOLD_CYCLES) @(posedge mclk);
        check_value("i2c_busy", 32'(i2c_busy), 32'd1);
        bus_quiet = 1'b0;
        host_write(1'b1, '0, ctrl_word(1'b0, 1'b1, 1'b1, 1'b0, 2'd0, 1'b0, '0));
        wait_drain();

        // reset command drops everything stored
        nbytes_model = 2'd1;
        host_write(1'b1, '0, ctrl_word(1'b0, 1'b1, 1'b0, 1'b1, nbytes_model, 1'b0, '0));
        repeat (3) queue_command('0, take_bits(32));
        repeat (2) queue_command(4'd2, take_bits(32));
        host_write(1'b1, '0, ctrl_word(1'b1, 1'b0, 1'b0, 1'b0, 2'd0, 1'b0, '0));
        exp_q.delete();
        pend_q.delete();
        open_model = '0;
        bus_quiet  = 1'b1;
        host_write(1'b1, '0, ctrl_word(1'b0, 1'b1, 1'b1, 1'b0, 2'd0, 1'b0, '0));
        repeat (8) pulse_frame_sync();     // open page walks over the pages written before
        repeat (HOLD_CYCLES) @(posedge mclk);
        check_value("i2c_busy", 32'(i2c_busy), 32'd0);
        bus_quiet = 1'b0;
        queue_command('0, take_bits(32));                      // bus still works
        wait_drain();

        if (writes_seen == N_SENT && exp_q.size() == 0 && pend_q.size() == 0) begin
            $display("Test OK");
            $finish;
        end else
            stop_on_error($sformatf("CHECK FAILED at %0t ns: writes_seen is %0d, expected %0d",
                                    $time, writes_seen, N_SENT));
    end

endmodule

`default_nettype wire
